//--- logic/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // stream and memory widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] byte_addr_t;

    // set bit keeps that byte lane unchanged
    typedef logic [3:0]  mask_t;
    typedef logic [2:0]  instr_t;

    // port instructions
    localparam instr_t INSTR_WRITE = 3'b000;
    localparam instr_t INSTR_READ  = 3'b001;

    // command nibbles of the first frame byte
    localparam logic [3:0] CMD_READ  = 4'hA;
    localparam logic [3:0] CMD_WRITE = 4'hB;

    // bank geometry, word index is byte address bits 7:2
    localparam int RAM_WORDS     = 64;
    localparam int RAM_ADDR_W    = 6;
    localparam int RD_FIFO_DEPTH = 4;

    // read reply framing
    localparam byte_t START_BYTE = 8'h01;
    localparam byte_t END_BYTE   = 8'h00;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_ADDR,
        ST_MEM_READ,
        ST_MEM_WRITE,
        ST_WAIT_LAST
    } bridge_state_t;

endpackage

//--- logic/mem_port.sv
`timescale 1ns/10ps

module mem_port import mem_bridge_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_en,
    input  instr_t     cmd_instr,
    input  byte_addr_t cmd_byte_addr,
    output logic       cmd_full,
    input  logic       wr_en,
    input  mask_t      wr_mask,
    input  word_t      wr_data,
    input  logic       rd_en,
    output word_t      rd_data,
    output logic       rd_empty
);

    word_t ram [RAM_WORDS];
    word_t fifo_mem [RD_FIFO_DEPTH];

    logic [RAM_ADDR_W-1:0] word_idx;
    logic [$clog2(RD_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(RD_FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(RD_FIFO_DEPTH):0] rd_count;
    logic  rd_pend;
    word_t rd_word;
    logic  wr_cmd;
    logic  rd_cmd;
    logic  pop;

    // higher address bits wrap onto the 64 words
    assign word_idx = cmd_byte_addr[RAM_ADDR_W+1:2];

    assign wr_cmd = cmd_en && wr_en && (cmd_instr == INSTR_WRITE);
    assign rd_cmd = cmd_en && (cmd_instr == INSTR_READ) && !cmd_full;
    assign pop    = rd_en && !rd_empty;

    assign rd_empty = (rd_count == '0);
    assign rd_data  = fifo_mem[rd_ptr];

    // a read in flight already owns a FIFO entry
    assign cmd_full = (int'(rd_count) + int'(rd_pend)) >= RD_FIFO_DEPTH;

    always_ff @(posedge clk) begin
        if (wr_cmd) begin
            for (int i = 0; i < $bits(mask_t); i++) begin
                if (!wr_mask[i]) begin
                    ram[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
        if (rd_cmd) begin
            rd_word <= ram[word_idx];
        end
        // word read last cycle enters the FIFO now
        if (rd_pend) begin
            fifo_mem[wr_ptr] <= rd_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_count <= '0;
        end else begin
            rd_pend <= rd_cmd;
            if (rd_pend) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({rd_pend, pop})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;
            endcase
        end
    end

endmodule

//--- logic/stream_mem_bridge.sv
`timescale 1ns/10ps

module stream_mem_bridge import mem_bridge_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  byte_t      in_tdata,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    output byte_t      out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,
    output logic       busy,
    output logic       p0_cmd_en,
    output instr_t     p0_cmd_instr,
    output byte_addr_t p0_cmd_byte_addr,
    input  logic       p0_cmd_full,
    output logic       p0_wr_en,
    output mask_t      p0_wr_mask,
    output word_t      p0_wr_data,
    output logic       p0_rd_en,
    input  word_t      p0_rd_data,
    input  logic       p0_rd_empty,
    output logic       p1_cmd_en,
    output instr_t     p1_cmd_instr,
    output byte_addr_t p1_cmd_byte_addr,
    input  logic       p1_cmd_full,
    output logic       p1_wr_en,
    output mask_t      p1_wr_mask,
    output word_t      p1_wr_data,
    output logic       p1_rd_en,
    input  word_t      p1_rd_data,
    input  logic       p1_rd_empty
);

    bridge_state_t state_q, state_d;
    byte_t      cmd_q, cmd_d;
    logic       bank_q, bank_d;
    logic [1:0] byte_cnt_q, byte_cnt_d;
    byte_addr_t addr_q, addr_d;
    logic       inc_addr_q, inc_addr_d;
    mask_t      skip_mask_q, skip_mask_d;
    mask_t      wr_mask_q, wr_mask_d;
    word_t      wr_data_q, wr_data_d;
    instr_t     instr_q, instr_d;
    word_t      hold_q, hold_d;
    logic       hold_valid_q, hold_valid_d;
    logic       start_sent_q, start_sent_d;
    logic       end_pend_q, end_pend_d;
    logic       rd_out_q, rd_out_d;
    logic [1:0] rd_settle_q, rd_settle_d;
    byte_t      out_tdata_q, out_tdata_d;
    logic       out_tvalid_q, out_tvalid_d;
    logic       out_tlast_q, out_tlast_d;
    logic       in_tready_q;
    logic       busy_q;
    logic       cmd_en;
    logic       wr_en;
    logic       rd_en;
    logic       p0_cmd_en_q, p1_cmd_en_q;
    logic       p0_wr_en_q, p1_wr_en_q;
    logic       p0_rd_en_q, p1_rd_en_q;
    word_t      p0_rd_data_q, p1_rd_data_q, rd_data_sel;
    logic       p0_rd_empty_q, p1_rd_empty_q, rd_empty_sel;
    logic       in_fire;
    logic       end_now;
    logic       out_free;
    logic       sel_cmd_full;

    assign in_fire      = in_tvalid && in_tready_q;
    assign end_now      = in_fire && in_tlast;
    assign out_free     = !out_tvalid_q || out_tready;
    assign sel_cmd_full = bank_q ? p1_cmd_full : p0_cmd_full;

    assign in_tready  = in_tready_q;
    assign out_tdata  = out_tdata_q;
    assign out_tvalid = out_tvalid_q;
    assign out_tlast  = out_tlast_q;
    assign busy       = busy_q;

    // instr, address, mask and data are common to both banks
    assign p0_cmd_en        = p0_cmd_en_q;
    assign p0_cmd_instr     = instr_q;
    assign p0_cmd_byte_addr = addr_q;
    assign p0_wr_en         = p0_wr_en_q;
    assign p0_wr_mask       = wr_mask_q;
    assign p0_wr_data       = wr_data_q;
    assign p0_rd_en         = p0_rd_en_q;
    assign p1_cmd_en        = p1_cmd_en_q;
    assign p1_cmd_instr     = instr_q;
    assign p1_cmd_byte_addr = addr_q;
    assign p1_wr_en         = p1_wr_en_q;
    assign p1_wr_mask       = wr_mask_q;
    assign p1_wr_data       = wr_data_q;
    assign p1_rd_en         = p1_rd_en_q;

    always_comb begin
        state_d      = state_q;
        cmd_d        = cmd_q;
        bank_d       = bank_q;
        byte_cnt_d   = byte_cnt_q;
        addr_d       = inc_addr_q ? addr_q + 32'd4 : addr_q;
        inc_addr_d   = 1'b0;
        skip_mask_d  = skip_mask_q;
        wr_mask_d    = wr_mask_q;
        wr_data_d    = wr_data_q;
        instr_d      = instr_q;
        hold_d       = hold_q;
        hold_valid_d = hold_valid_q;
        start_sent_d = start_sent_q;
        end_pend_d   = end_pend_q;
        rd_out_d     = rd_out_q;
        rd_settle_d  = rd_settle_q;
        out_tdata_d  = out_tdata_q;
        out_tvalid_d = out_tvalid_q && !out_tready;
        out_tlast_d  = out_tvalid_d ? out_tlast_q : 1'b0;
        cmd_en       = 1'b0;
        wr_en        = 1'b0;
        rd_en        = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // drain words left over from an earlier read
                rd_en        = 1'b1;
                hold_valid_d = 1'b0;
                start_sent_d = 1'b0;
                end_pend_d   = 1'b0;
                rd_out_d     = 1'b0;
                rd_settle_d  = 2'd0;
                if (in_fire) begin
                    cmd_d = in_tdata;
                    if (in_tlast) begin
                        state_d = ST_IDLE;
                    end else if ((in_tdata[7:4] == CMD_READ || in_tdata[7:4] == CMD_WRITE)
                                 && in_tdata[3:0] <= 4'd1) begin
                        bank_d     = in_tdata[0];
                        byte_cnt_d = 2'd0;
                        state_d    = ST_READ_ADDR;
                    end else begin
                        state_d = ST_WAIT_LAST;
                    end
                end
            end
            ST_READ_ADDR: begin
                rd_en = 1'b1;
                if (in_fire) begin
                    byte_cnt_d = byte_cnt_q + 2'd1;
                    case (byte_cnt_q)
                        2'd0: addr_d[31:24] = in_tdata;
                        2'd1: addr_d[23:16] = in_tdata;
                        2'd2: addr_d[15:8]  = in_tdata;
                        default: begin
                            addr_d[7:0] = {in_tdata[7:2], 2'b00};
                            byte_cnt_d  = in_tdata[1:0];
                            // lanes below the start byte stay untouched
                            skip_mask_d = mask_t'((4'b0001 << in_tdata[1:0]) - 4'b0001);
                        end
                    endcase
                    if (in_tlast) begin
                        state_d = ST_IDLE;
                    end else if (byte_cnt_q == 2'd3) begin
                        state_d = (cmd_q[7:4] == CMD_READ) ? ST_MEM_READ : ST_MEM_WRITE;
                    end
                end
            end
            ST_MEM_WRITE: begin
                rd_en = 1'b1;
                if (in_fire) begin
                    wr_data_d[8*byte_cnt_q +: 8] = in_tdata;
                    byte_cnt_d = byte_cnt_q + 2'd1;
                    if (in_tlast || byte_cnt_q == 2'd3) begin
                        wr_mask_d   = skip_mask_q | mask_t'(4'b1110 << byte_cnt_q);
                        skip_mask_d = '0;
                        instr_d     = INSTR_WRITE;
                        cmd_en      = 1'b1;
                        wr_en       = 1'b1;
                        inc_addr_d  = 1'b1;
                        if (in_tlast) begin
                            state_d = ST_IDLE;
                        end
                    end
                end
            end
            ST_MEM_READ: begin
                // host bytes are dropped until last
                if (end_now) begin
                    end_pend_d = 1'b1;
                end
                if (out_free) begin
                    if (!start_sent_q) begin
                        out_tdata_d  = START_BYTE;
                        out_tvalid_d = 1'b1;
                        out_tlast_d  = 1'b0;
                        start_sent_d = 1'b1;
                    end else if (end_pend_q || end_now) begin
                        out_tdata_d  = END_BYTE;
                        out_tvalid_d = 1'b1;
                        out_tlast_d  = 1'b1;
                        end_pend_d   = 1'b0;
                        state_d      = ST_IDLE;
                    end else if (hold_valid_q) begin
                        out_tdata_d  = hold_q[8*byte_cnt_q +: 8];
                        out_tvalid_d = 1'b1;
                        out_tlast_d  = 1'b0;
                        byte_cnt_d   = byte_cnt_q + 2'd1;
                        if (byte_cnt_q == 2'd3) begin
                            hold_valid_d = 1'b0;
                        end
                    end
                end
                if (state_d == ST_MEM_READ) begin
                    if (rd_settle_q != 2'd0) begin
                        rd_settle_d = rd_settle_q - 2'd1;
                    end
                    // empty flag lags the FIFO, so wait for the pop to show
                    if (!hold_valid_d && rd_out_q && rd_settle_q == 2'd0 && !rd_empty_sel) begin
                        hold_d       = rd_data_sel;
                        hold_valid_d = 1'b1;
                        rd_en        = 1'b1;
                        rd_out_d     = 1'b0;
                        rd_settle_d  = 2'd3;
                    end
                    if (!rd_out_d && !sel_cmd_full) begin
                        instr_d    = INSTR_READ;
                        cmd_en     = 1'b1;
                        inc_addr_d = 1'b1;
                        rd_out_d   = 1'b1;
                    end
                end
            end
            ST_WAIT_LAST: begin
                rd_en = 1'b1;
                if (end_now) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= ST_IDLE;
            bank_q        <= 1'b0;
            byte_cnt_q    <= 2'd0;
            inc_addr_q    <= 1'b0;
            hold_valid_q  <= 1'b0;
            start_sent_q  <= 1'b0;
            end_pend_q    <= 1'b0;
            rd_out_q      <= 1'b0;
            rd_settle_q   <= 2'd0;
            out_tvalid_q  <= 1'b0;
            out_tlast_q   <= 1'b0;
            in_tready_q   <= 1'b0;
            busy_q        <= 1'b0;
            p0_cmd_en_q   <= 1'b0;
            p1_cmd_en_q   <= 1'b0;
            p0_wr_en_q    <= 1'b0;
            p1_wr_en_q    <= 1'b0;
            p0_rd_en_q    <= 1'b0;
            p1_rd_en_q    <= 1'b0;
            p0_rd_empty_q <= 1'b1;
            p1_rd_empty_q <= 1'b1;
            rd_empty_sel  <= 1'b1;
        end else begin
            state_q       <= state_d;
            bank_q        <= bank_d;
            byte_cnt_q    <= byte_cnt_d;
            inc_addr_q    <= inc_addr_d;
            hold_valid_q  <= hold_valid_d;
            start_sent_q  <= start_sent_d;
            end_pend_q    <= end_pend_d;
            rd_out_q      <= rd_out_d;
            rd_settle_q   <= rd_settle_d;
            out_tvalid_q  <= out_tvalid_d;
            out_tlast_q   <= out_tlast_d;
            in_tready_q   <= 1'b1;
            busy_q        <= (state_d != ST_IDLE);
            // enables go to the selected bank only
            p0_cmd_en_q   <= cmd_en && !bank_q;
            p1_cmd_en_q   <= cmd_en && bank_q;
            p0_wr_en_q    <= wr_en && !bank_q;
            p1_wr_en_q    <= wr_en && bank_q;
            p0_rd_en_q    <= rd_en && !bank_q;
            p1_rd_en_q    <= rd_en && bank_q;
            p0_rd_empty_q <= p0_rd_empty;
            p1_rd_empty_q <= p1_rd_empty;
            rd_empty_sel  <= bank_q ? p1_rd_empty_q : p0_rd_empty_q;
        end
    end

    always_ff @(posedge clk) begin
        cmd_q        <= cmd_d;
        addr_q       <= addr_d;
        skip_mask_q  <= skip_mask_d;
        wr_mask_q    <= wr_mask_d;
        wr_data_q    <= wr_data_d;
        instr_q      <= instr_d;
        hold_q       <= hold_d;
        out_tdata_q  <= out_tdata_d;
        p0_rd_data_q <= p0_rd_data;
        p1_rd_data_q <= p1_rd_data;
        rd_data_sel  <= bank_q ? p1_rd_data_q : p0_rd_data_q;
    end

endmodule

//--- logic/mem_bridge_top.sv
`timescale 1ns/10ps

module mem_bridge_top import mem_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,
    input  logic  in_tlast,
    output byte_t out_tdata,
    output logic  out_tvalid,
    input  logic  out_tready,
    output logic  out_tlast,
    output logic  busy
);

    logic       p0_cmd_en, p1_cmd_en;
    instr_t     p0_cmd_instr, p1_cmd_instr;
    byte_addr_t p0_cmd_byte_addr, p1_cmd_byte_addr;
    logic       p0_cmd_full, p1_cmd_full;
    logic       p0_wr_en, p1_wr_en;
    mask_t      p0_wr_mask, p1_wr_mask;
    word_t      p0_wr_data, p1_wr_data;
    logic       p0_rd_en, p1_rd_en;
    word_t      p0_rd_data, p1_rd_data;
    logic       p0_rd_empty, p1_rd_empty;

    // all port names match the local nets
    stream_mem_bridge bridge_i (.*);

    mem_port bank0_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_en        (p0_cmd_en),
        .cmd_instr     (p0_cmd_instr),
        .cmd_byte_addr (p0_cmd_byte_addr),
        .cmd_full      (p0_cmd_full),
        .wr_en         (p0_wr_en),
        .wr_mask       (p0_wr_mask),
        .wr_data       (p0_wr_data),
        .rd_en         (p0_rd_en),
        .rd_data       (p0_rd_data),
        .rd_empty      (p0_rd_empty)
    );

    mem_port bank1_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_en        (p1_cmd_en),
        .cmd_instr     (p1_cmd_instr),
        .cmd_byte_addr (p1_cmd_byte_addr),
        .cmd_full      (p1_cmd_full),
        .wr_en         (p1_wr_en),
        .wr_mask       (p1_wr_mask),
        .wr_data       (p1_wr_data),
        .rd_en         (p1_rd_en),
        .rd_data       (p1_rd_data),
        .rd_empty      (p1_rd_empty)
    );

endmodule

//--- verif/mem_bridge_properties.sv
`timescale 1ns/10ps

module mem_bridge_properties import mem_bridge_pkg::*; (
    input logic   clk,
    input logic   rst,
    input byte_t  out_tdata,
    input logic   out_tvalid,
    input logic   out_tready,
    input logic   out_tlast,
    input logic   p0_cmd_en,
    input logic   p1_cmd_en,
    input instr_t p0_cmd_instr,
    input instr_t p1_cmd_instr,
    input logic   p0_cmd_full,
    input logic   p1_cmd_full
);

    // a waiting output byte stays put
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
        else $error("output byte changed while waiting for ready");

    one_bank: assert property (@(posedge clk) disable iff (rst)
        !(p0_cmd_en && p1_cmd_en))
        else $error("both banks got cmd_en in the same cycle");

    p0_no_full_read: assert property (@(posedge clk) disable iff (rst)
        p0_cmd_en && p0_cmd_instr == INSTR_READ |-> !p0_cmd_full)
        else $error("read issued to bank 0 while cmd_full");

    p1_no_full_read: assert property (@(posedge clk) disable iff (rst)
        p1_cmd_en && p1_cmd_instr == INSTR_READ |-> !p1_cmd_full)
        else $error("read issued to bank 1 while cmd_full");

endmodule

//--- verif/mem_bridge_tb.sv
`timescale 1ns/10ps

module mem_bridge_tb import mem_bridge_pkg::*; ();

    localparam logic [31:0] SEED = 32'h60d7;
    localparam int CYCLES_PER_BYTE = 40;
    localparam int TIMEOUT_MARGIN = 200;

    logic  clk = 1'b0;
    logic  rst;
    byte_t in_tdata;
    logic  in_tvalid;
    logic  in_tready;
    logic  in_tlast;
    byte_t out_tdata;
    logic  out_tvalid;
    logic  out_tready;
    logic  out_tlast;
    logic  busy;

    logic [31:0] lfsr;
    int    cycles = 0;
    int    limit = 0;
    int    mismatches = 0;
    int    failures = 0;
    logic  in_taken = 1'b0;
    byte_t rx_data[$];
    logic  rx_last[$];
    byte_t ref_mem [2][256];
    logic  ref_known [2][256];
    string entry_kind[$];
    int    entry_n[$];
    int    entry_arg[$];
    int    entry_wait[$];
    word_t entry_word[$];
    byte_t frame_bytes[$];

    mem_bridge_top dut_i (.*);

    bind stream_mem_bridge mem_bridge_properties props_i (.*);

    always #10 clk = ~clk;

    // transfers seen on the rising edge and the run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        in_taken = in_tvalid && in_tready;
        if (out_tvalid && out_tready) begin
            rx_data.push_back(out_tdata);
            rx_last.push_back(out_tlast);
        end
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // galois form stepped once per bit
    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    endtask

    task automatic next_cycle();
        logic b1;
        logic b2;
        @(negedge clk);
        take_bit(b1);
        take_bit(b2);
        out_tready = b1 | b2;
    endtask

    task automatic send_byte(input byte_t data, input logic last);
        logic gap;
        take_bit(gap);
        if (gap) begin
            next_cycle();
        end
        in_tdata  = data;
        in_tvalid = 1'b1;
        in_tlast  = last;
        do begin
            next_cycle();
        end while (!in_taken);
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
    endtask

    task automatic finish_frame(input int num);
        while (busy) begin
            next_cycle();
        end
        assert (in_tready) else begin
            $display("in_tready is low after frame %0d", num);
            failures++;
        end
        // the last write word lands one edge after busy falls
        next_cycle();
    endtask

    // only valid write commands touch the reference banks
    task automatic apply_write(input int start, input int n);
        byte_t cmd;
        byte_t a;
        cmd = frame_bytes[start];
        if (cmd[7:4] == CMD_WRITE && cmd[3:0] <= 4'd1) begin
            a = frame_bytes[start+4];
            for (int i = 5; i < n; i++) begin
                ref_mem[cmd[0]][a] = frame_bytes[start+i];
                ref_known[cmd[0]][a] = 1'b1;
                a = a + 8'd1;
            end
        end
    endtask

    task automatic run_frame(input int num, input int start, input int n);
        rx_data.delete();
        rx_last.delete();
        for (int i = 0; i < n; i++) begin
            send_byte(frame_bytes[start+i], i == n - 1);
        end
        apply_write(start, n);
        finish_frame(num);
        assert (rx_data.size() == 0) else begin
            $display("frame %0d returned %0d output bytes, none expected", num, rx_data.size());
            failures++;
        end
    endtask

    task automatic run_read(input int num, input int start, input int n, input int wait_n);
        int    bank;
        byte_t a;
        int    last_i;
        bank = frame_bytes[start][0];
        a = frame_bytes[start+4];
        rx_data.delete();
        rx_last.delete();
        for (int i = 0; i < n; i++) begin
            send_byte(frame_bytes[start+i], 1'b0);
        end
        // a reply that closes early stops the wait as well
        while (rx_data.size() < wait_n + 1 && !(rx_last.size() > 0 && rx_last[$])) begin
            next_cycle();
        end
        send_byte(8'hff, 1'b1);
        while (rx_last.size() == 0 || !rx_last[$]) begin
            next_cycle();
        end
        last_i = rx_data.size() - 1;
        assert (rx_data[0] == START_BYTE) else begin
            $display("MISMATCH out_tdata start byte exp %h got %h", START_BYTE, rx_data[0]);
            mismatches++;
        end
        for (int k = 1; k < last_i; k++) begin
            if (ref_known[bank][a]) begin
                assert (rx_data[k] == ref_mem[bank][a]) else begin
                    $display("MISMATCH out_tdata byte %0d exp %h got %h",
                             k - 1, ref_mem[bank][a], rx_data[k]);
                    mismatches++;
                end
            end
            assert (!rx_last[k]) else begin
                $display("frame %0d has last set on data byte %0d", num, k - 1);
                failures++;
            end
            a = a + 8'd1;
        end
        assert (last_i > 0 && rx_data[last_i] == END_BYTE) else begin
            $display("MISMATCH out_tdata end byte exp %h got %h", END_BYTE, rx_data[last_i]);
            mismatches++;
        end
        assert (last_i - 1 >= wait_n) else begin
            $display("read reply ended after %0d data bytes, %0d awaited", last_i - 1, wait_n);
            failures++;
        end
        finish_frame(num);
    endtask

    task automatic check_word(input int bank, input int idx, input word_t exp);
        word_t model;
        word_t ram;
        model = {ref_mem[bank][4*idx+3], ref_mem[bank][4*idx+2],
                 ref_mem[bank][4*idx+1], ref_mem[bank][4*idx]};
        ram = (bank == 0) ? dut_i.bank0_i.ram[idx] : dut_i.bank1_i.ram[idx];
        assert (model === exp) else begin
            $display("MISMATCH ref_word bank %0d word %0d exp %h got %h", bank, idx, exp, model);
            mismatches++;
        end
        assert (ram === exp) else begin
            $display("MISMATCH ram bank %0d word %0d exp %h got %h", bank, idx, exp, ram);
            mismatches++;
        end
    endtask

    task automatic load_patterns(output int total);
        int    fd;
        int    code;
        int    n;
        int    w;
        int    bank;
        int    idx;
        byte_t b;
        word_t word;
        string tok;
        string line;
        total = 0;
        fd = $fopen("verif/mem_bridge_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            failures++;
            return;
        end
        while (1) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.getc(0) == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "W" || tok == "D" || tok == "R") begin
                code = $fscanf(fd, " %d", n);
                entry_arg.push_back(frame_bytes.size());
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, " %h", b);
                    frame_bytes.push_back(b);
                end
                w = 0;
                if (tok == "R") begin
                    code = $fscanf(fd, " %d", w);
                    total += w + 3;
                end
                total += n;
                entry_kind.push_back(tok);
                entry_n.push_back(n);
                entry_wait.push_back(w);
                entry_word.push_back('0);
            end else if (tok == "C") begin
                code = $fscanf(fd, " %d %d %h", bank, idx, word);
                entry_kind.push_back(tok);
                entry_n.push_back(bank);
                entry_arg.push_back(idx);
                entry_wait.push_back(0);
                entry_word.push_back(word);
            end else begin
                $display("unknown line type %s in the pattern file", tok);
                failures++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int total;
        rst        = 1'b1;
        in_tdata   = '0;
        in_tvalid  = 1'b0;
        in_tlast   = 1'b0;
        out_tready = 1'b0;
        lfsr       = SEED;
        for (int bk = 0; bk < 2; bk++) begin
            for (int a = 0; a < 256; a++) begin
                ref_known[bk][a] = 1'b0;
            end
        end
        load_patterns(total);
        limit = CYCLES_PER_BYTE * total + TIMEOUT_MARGIN;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        next_cycle();
        next_cycle();
        assert (!busy && in_tready) else begin
            $display("busy high or in_tready low after reset");
            failures++;
        end
        for (int e = 0; e < entry_kind.size(); e++) begin
            case (entry_kind[e])
                "R": run_read(e, entry_arg[e], entry_n[e], entry_wait[e]);
                "C": check_word(entry_n[e], entry_arg[e], entry_word[e]);
                default: run_frame(e, entry_arg[e], entry_n[e]);
            endcase
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- mem_bridge_top.f
logic/mem_bridge_pkg.sv
logic/mem_port.sv
logic/stream_mem_bridge.sv
logic/mem_bridge_top.sv
verif/mem_bridge_properties.sv
verif/mem_bridge_tb.sv

//--- Bender.yml
package:
  name: mem_bridge

sources:
  - logic/mem_bridge_pkg.sv
  - logic/mem_port.sv
  - logic/stream_mem_bridge.sv
  - logic/mem_bridge_top.sv
  - target: test
    files:
      - verif/mem_bridge_properties.sv
      - verif/mem_bridge_tb.sv

//--- verif/mem_bridge_patterns.txt
# frames: W|D <byte count> <bytes in hex>, last is set on the final byte
# reads:  R <byte count> <cmd and address bytes> <data bytes awaited before last>
# checks: C <bank> <word index> <expected word in hex>
W 21 B0 00 00 00 00 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
C 0 0 13121110
C 0 3 1f1e1d1c
W 21 B0 00 00 00 10 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
C 0 4 23222120
C 0 7 2f2e2d2c
W 21 B1 00 00 00 00 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
C 1 0 83828180
C 1 3 8f8e8d8c
# full words back from each bank
R 5 A0 00 00 00 00 8
R 5 A1 00 00 00 00 8
# high address bits wrap onto words 62 and 63
W 13 B1 12 34 56 F8 f0 f1 f2 f3 f4 f5 f6 f7
C 1 62 f3f2f1f0
C 1 63 f7f6f5f4
# unaligned and short writes
W 8 B0 00 00 00 06 a1 a2 a3
C 0 1 a2a11514
C 0 2 1b1a19a3
W 6 B0 00 00 00 19 c5
C 0 6 2b2ac528
W 7 B1 00 00 00 01 55 66
C 1 0 83665580
R 5 A0 00 00 00 06 6
R 5 A0 00 00 00 00 12
# unknown command and bank above 1
D 9 C0 00 00 00 00 11 22 33 44
C 0 0 13121110
D 9 B2 00 00 00 04 99 99 99 99
C 1 1 87868584
C 0 1 a2a11514
D 5 A5 00 00 00 00
# reply across word 63 into word 0
R 5 A1 00 00 01 F8 16
R 5 A1 00 00 00 00 4
